/* all.f */
brickGamePkg.sv
paddleControl.sv
ballMotion.sv
brickField.sv
gameStatus.sv
brickGame.sv
brickGame_assertions.sv
brickGameTb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module brickGameTb --Mdir obj_dir -o brickGameSim -f all.f
	./obj_dir/brickGameSim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* brickGameTb.sv */
`default_nettype none

module brickGameTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int maxFrames = 6000;
    localparam int freezeFrames = 16;
    localparam int maskWidth = brickGamePkg::brickCount;
    localparam int cols = brickGamePkg::brickCols;
    localparam int ball = brickGamePkg::ballSize;
    localparam int rightEdge = brickGamePkg::screenWidth;
    localparam int bottomEdge = brickGamePkg::screenHeight;
    localparam int paddleMax = rightEdge - brickGamePkg::paddleWidth;
    // Held ball centred on the paddle
    localparam int holdOffset = brickGamePkg::paddleWidth / 2 - ball / 2;
    localparam int holdY = brickGamePkg::paddleY - ball - brickGamePkg::holdGap;

    logic nextFrame;
    logic rstN;
    brickGamePkg::controlT control;
    brickGamePkg::coordT paddleX;
    brickGamePkg::pointT ballPos;
    logic ballHeld;
    logic [maskWidth-1:0] brickMask;
    logic [15:0] score;
    logic [1:0] lives;
    logic gameOver;

    integer seed;
    logic sweepRight;

    // Reference model state
    int mPaddle;
    int mBallX;
    int mBallY;
    int mVelX;
    int mVelY;
    logic mHeld;
    logic [maskWidth-1:0] mMask;
    int mScore;
    int mLives;
    logic mOver;

    brickGame #(
        .screenWidth(brickGamePkg::screenWidth),
        .screenHeight(brickGamePkg::screenHeight),
        .brickRows(brickGamePkg::brickRows),
        .brickCols(brickGamePkg::brickCols)
    ) DUT (
        .nextFrame(nextFrame),
        .rstN(rstN),
        .control(control),
        .paddleX(paddleX),
        .ballPos(ballPos),
        .ballHeld(ballHeld),
        .brickMask(brickMask),
        .score(score),
        .lives(lives),
        .gameOver(gameOver)
    );

    always #4 nextFrame = ~nextFrame;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic checkCoord(input string name, input brickGamePkg::coordT expected,
                              input brickGamePkg::coordT actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic checkPoint(input string name, input brickGamePkg::pointT expected,
                              input brickGamePkg::pointT actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic checkMask(input string name, input logic [maskWidth-1:0] expected,
                             input logic [maskWidth-1:0] actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic checkCount(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    // Lowest live brick whose box overlaps the ball box, or -1
    function automatic int findBrick(input int x, input int y);
        int left;
        int top;
        int hit;
        hit = -1;
        for (int i = 0; i < maskWidth; i++) begin
            left = brickGamePkg::brickOriginX + (i % cols) * brickGamePkg::brickPitchX;
            top = brickGamePkg::brickOriginY + (i / cols) * brickGamePkg::brickPitchY;
            if (hit < 0 && mMask[i] && x + ball > left && x < left + brickGamePkg::brickWidth
                    && y + ball > top && y < top + brickGamePkg::brickHeight) begin
                hit = i;
            end
        end
        return hit;
    endfunction

    task automatic resetModel();
        mPaddle = brickGamePkg::paddleStartX;
        mBallX = mPaddle + holdOffset;
        mBallY = holdY;
        mVelX = 0;
        mVelY = 0;
        mHeld = 1'b1;
        mMask = '1;
        mScore = 0;
        mLives = brickGamePkg::startLives;
        mOver = 1'b0;
    endtask

    // One game update, as applied at the next rising edge
    task automatic stepModel(input brickGamePkg::controlT c);
        int nextPaddle;
        int nx;
        int ny;
        int hit;
        if (!mOver) begin
            nextPaddle = mPaddle;
            if (c.moveLeft) begin
                nextPaddle = (mPaddle < brickGamePkg::paddleSpeed) ? 0
                           : mPaddle - brickGamePkg::paddleSpeed;
            end else if (c.moveRight) begin
                nextPaddle = (mPaddle + brickGamePkg::paddleSpeed > paddleMax) ? paddleMax
                           : mPaddle + brickGamePkg::paddleSpeed;
            end
            nx = mBallX + mVelX;
            ny = mBallY + mVelY;
            if (mHeld) begin
                mBallX = mPaddle + holdOffset;
                mBallY = holdY;
                if (c.launch) begin
                    mHeld = 1'b0;
                    mVelX = -brickGamePkg::launchVelocity;
                    mVelY = -brickGamePkg::launchVelocity;
                end
            end else if (nx < 0) begin
                mBallX = 0;
                mBallY = ny;
                mVelX = -mVelX;
            end else if (nx + ball >= rightEdge) begin
                mBallX = rightEdge - ball;
                mBallY = ny;
                mVelX = -mVelX;
            end else if (ny < 0) begin
                mBallX = nx;
                mBallY = 0;
                mVelY = -mVelY;
            end else if (ny + ball >= bottomEdge) begin
                // Lost ball returns to the old paddle position
                mHeld = 1'b1;
                mBallX = mPaddle + holdOffset;
                mBallY = holdY;
                mVelX = 0;
                mVelY = 0;
                mLives = mLives - 1;
                mOver = (mLives == 0);
            end else begin
                mBallX = nx;
                mBallY = ny;
                hit = findBrick(nx, ny);
                if (hit >= 0) begin
                    mMask[hit] = 1'b0;
                    mVelY = -mVelY;
                    mScore = mScore + brickGamePkg::brickScore;
                end
            end
            mPaddle = nextPaddle;
        end
    endtask

    task automatic compareOutputs();
        brickGamePkg::pointT expPos;
        expPos.x = brickGamePkg::coordT'(mBallX);
        expPos.y = brickGamePkg::coordT'(mBallY);
        checkCoord("paddleX", brickGamePkg::coordT'(mPaddle), paddleX);
        checkPoint("ballPos", expPos, ballPos);
        checkFlag("ballHeld", mHeld, ballHeld);
        checkMask("brickMask", mMask, brickMask);
        checkCount("score", 16'(mScore), score);
        checkCount("lives", 16'(mLives), {14'd0, lives});
        checkFlag("gameOver", mOver, gameOver);
    endtask

    task automatic drawControl(output brickGamePkg::controlT c);
        logic [31:0] r;
        r = $random(seed);
        // Moves favour the sweep direction so that both clamps are reached
        // Both moves together on about one frame in eight
        if (sweepRight) begin
            c.moveRight = r[0] | r[1];
            c.moveLeft = r[0] & r[1] & r[2];
        end else begin
            c.moveLeft = r[0] | r[1];
            c.moveRight = r[0] & r[1] & r[2];
        end
        // Launch on about one frame in eight
        c.launch = (r[6:4] == 3'd0);
    endtask

    // Drive on the falling edge, check at the next falling edge
    task automatic playFrame();
        brickGamePkg::controlT c;
        drawControl(c);
        control = c;
        stepModel(c);
        // Turn the sweep around at either edge
        if (mPaddle == paddleMax) begin
            sweepRight = 1'b0;
        end else if (mPaddle == 0) begin
            sweepRight = 1'b1;
        end
        @(negedge nextFrame);
        compareOutputs();
    endtask

    initial begin
        int frame;
        nextFrame = 1'b0;
        rstN = 1'b0;
        control = '0;
        seed = 32'hf8ad70bb;
        sweepRight = 1'b1;
        resetModel();
        for (int i = 0; i < 10; i++) begin
            @(negedge nextFrame);
        end
        compareOutputs();
        rstN = 1'b1;
        frame = 0;
        while (!mOver && frame < maxFrames) begin
            playFrame();
            frame++;
        end
        if (!mOver) begin
            failRun("timeout, the game did not end within the frame limit");
        end else begin
            // Everything must stay frozen after game over
            for (int i = 0; i < freezeFrames; i++) begin
                playFrame();
            end
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* brickGame_assertions.sv */
`default_nettype none

module brickGameAssertions #(
    parameter int maskWidth = 32,
    parameter int maxPaddleX = 560
) (
    input logic                  nextFrame,
    input logic                  rstN,
    input brickGamePkg::coordT   paddleX,
    input logic [maskWidth-1:0]  brickMask,
    input logic [1:0]            lives,
    input logic                  gameOver
);

    timeunit 1ns;
    timeprecision 100ps;

    // Game over latches until reset
    gameOverHolds: assert property (@(posedge nextFrame)
        $past(rstN) && $past(gameOver) |-> gameOver)
        else $error("gameOver fell without a reset");

    // Lives only count down until reset
    livesNeverRise: assert property (@(posedge nextFrame)
        $past(rstN) |-> lives <= $past(lives))
        else $error("lives rose without a reset");

    // Bricks only ever get cleared
    bricksOnlyClear: assert property (@(posedge nextFrame)
        $past(rstN) |-> (brickMask & ~$past(brickMask)) == '0)
        else $error("a brick came back without a reset");

    paddleOnScreen: assert property (@(posedge nextFrame) disable iff (!rstN)
        paddleX >= 0 && paddleX <= maxPaddleX)
        else $error("paddle left the screen");

endmodule

bind brickGame brickGameAssertions #(
    .maskWidth(brickRows * brickCols),
    .maxPaddleX(screenWidth - brickGamePkg::paddleWidth)
) outputChecks (
    .nextFrame(nextFrame),
    .rstN(rstN),
    .paddleX(paddleX),
    .brickMask(brickMask),
    .lives(lives),
    .gameOver(gameOver)
);

`default_nettype wire

/* brickGame.sv */
`default_nettype none

module brickGame #(
    parameter int screenWidth = brickGamePkg::screenWidth,
    parameter int screenHeight = brickGamePkg::screenHeight,
    parameter int brickRows = brickGamePkg::brickRows,
    parameter int brickCols = brickGamePkg::brickCols
) (
    input  logic                               nextFrame,
    input  logic                               rstN,
    input  brickGamePkg::controlT              control,
    output brickGamePkg::coordT                paddleX,
    output brickGamePkg::pointT                ballPos,
    output logic                               ballHeld,
    output logic [brickRows * brickCols - 1:0] brickMask,
    output logic [15:0]                        score,
    output logic [1:0]                         lives,
    output logic                               gameOver
);

    brickGamePkg::pointT candidate;
    logic checkBricks;
    logic brickHit;
    logic lifeLost;

    paddleControl #(
        .screenWidth(screenWidth)
    ) paddle (
        .nextFrame(nextFrame),
        .rstN(rstN),
        .control(control),
        .gameOver(gameOver),
        .paddleX(paddleX)
    );

    ballMotion #(
        .screenWidth(screenWidth),
        .screenHeight(screenHeight)
    ) ball (
        .nextFrame(nextFrame),
        .rstN(rstN),
        .control(control),
        .paddleX(paddleX),
        .brickHit(brickHit),
        .gameOver(gameOver),
        .candidate(candidate),
        .checkBricks(checkBricks),
        .lifeLost(lifeLost),
        .ballPos(ballPos),
        .ballHeld(ballHeld)
    );

    // Combinational hit answer within the same frame
    brickField #(
        .brickRows(brickRows),
        .brickCols(brickCols)
    ) bricks (
        .nextFrame(nextFrame),
        .rstN(rstN),
        .candidate(candidate),
        .checkBricks(checkBricks),
        .brickHit(brickHit),
        .brickMask(brickMask)
    );

    gameStatus status (
        .nextFrame(nextFrame),
        .rstN(rstN),
        .lifeLost(lifeLost),
        .brickHit(brickHit),
        .lives(lives),
        .score(score),
        .gameOver(gameOver)
    );

endmodule

`default_nettype wire

/* gameStatus.sv */
`default_nettype none

module gameStatus (
    input  logic        nextFrame,
    input  logic        rstN,
    input  logic        lifeLost,
    input  logic        brickHit,
    output logic [1:0]  lives,
    output logic [15:0] score,
    output logic        gameOver
);

    localparam logic [15:0] hitPoints = 16'(brickGamePkg::brickScore);
    localparam logic [1:0] fullLives = 2'(brickGamePkg::startLives);

    always_ff @(posedge nextFrame) begin
        if (!rstN) begin
            lives <= fullLives;
            score <= '0;
            gameOver <= 1'b0;
        end else if (!gameOver) begin
            if (brickHit) begin
                score <= score + hitPoints;
            end
            if (lifeLost) begin
                lives <= lives - 2'd1;
                // Last life gone, freeze from the next frame on
                if (lives == 2'd1) begin
                    gameOver <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* brickField.sv */
`default_nettype none

module brickField #(
    parameter int brickRows = brickGamePkg::brickRows,
    parameter int brickCols = brickGamePkg::brickCols
) (
    input  logic                               nextFrame,
    input  logic                               rstN,
    input  brickGamePkg::pointT                candidate,
    input  logic                               checkBricks,
    output logic                               brickHit,
    output logic [brickRows * brickCols - 1:0] brickMask
);

    localparam int brickCount = brickRows * brickCols;

    // One-hot select of the brick to clear this frame
    logic [brickCount-1:0] hitSelect;
    logic found;

    always_comb begin
        int ballLeft;
        int ballTop;
        int brickLeft;
        int brickTop;
        int index;

        ballLeft = int'(candidate.x);
        ballTop = int'(candidate.y);
        hitSelect = '0;
        found = 1'b0;
        // Row-major scan so the lowest index wins
        for (int row = 0; row < brickRows; row++) begin
            for (int col = 0; col < brickCols; col++) begin
                index = row * brickCols + col;
                brickLeft = brickGamePkg::brickOriginX + col * brickGamePkg::brickPitchX;
                brickTop = brickGamePkg::brickOriginY + row * brickGamePkg::brickPitchY;
                // Strict box overlap on all four sides
                if (!found && brickMask[index]
                        && ballLeft < brickLeft + brickGamePkg::brickWidth
                        && ballLeft + brickGamePkg::ballSize > brickLeft
                        && ballTop < brickTop + brickGamePkg::brickHeight
                        && ballTop + brickGamePkg::ballSize > brickTop) begin
                    found = 1'b1;
                    hitSelect[index] = 1'b1;
                end
            end
        end
        brickHit = checkBricks && found;
    end

    always_ff @(posedge nextFrame) begin
        if (!rstN) begin
            brickMask <= '1;
        end else if (brickHit) begin
            brickMask <= brickMask & ~hitSelect;
        end
    end

endmodule

`default_nettype wire

/* ballMotion.sv */
`default_nettype none

module ballMotion #(
    parameter int screenWidth = brickGamePkg::screenWidth,
    parameter int screenHeight = brickGamePkg::screenHeight
) (
    input  logic                  nextFrame,
    input  logic                  rstN,
    input  brickGamePkg::controlT control,
    input  brickGamePkg::coordT   paddleX,
    input  logic                  brickHit,
    input  logic                  gameOver,
    output brickGamePkg::pointT   candidate,
    output logic                  checkBricks,
    output logic                  lifeLost,
    output brickGamePkg::pointT   ballPos,
    output logic                  ballHeld
);

    // Held ball is centred on the paddle, a small gap above it
    localparam brickGamePkg::coordT holdOffset = brickGamePkg::coordT'(
        brickGamePkg::paddleWidth / 2 - brickGamePkg::ballSize / 2);
    localparam brickGamePkg::coordT heldY = brickGamePkg::coordT'(
        brickGamePkg::paddleY - brickGamePkg::ballSize - brickGamePkg::holdGap);
    localparam brickGamePkg::coordT resetX =
        brickGamePkg::coordT'(brickGamePkg::paddleStartX) + holdOffset;

    localparam brickGamePkg::coordT size =
        brickGamePkg::coordT'(brickGamePkg::ballSize);
    localparam brickGamePkg::coordT rightLimit =
        brickGamePkg::coordT'(screenWidth - brickGamePkg::ballSize);
    localparam brickGamePkg::coordT launchStep =
        brickGamePkg::coordT'(-brickGamePkg::launchVelocity);

    brickGamePkg::pointT velocity;
    brickGamePkg::coordT heldX;
    logic moving;
    logic hitLeft;
    logic hitRight;
    logic hitTop;
    logic hitBottom;

    always_comb begin
        moving = !ballHeld && !gameOver;
        heldX = paddleX + holdOffset;
        candidate.x = ballPos.x + velocity.x;
        candidate.y = ballPos.y + velocity.y;

        // Wall tests on the candidate box
        hitLeft = candidate.x < 0;
        hitRight = (candidate.x + size) >= brickGamePkg::coordT'(screenWidth);
        hitTop = candidate.y < 0;
        hitBottom = (candidate.y + size) >= brickGamePkg::coordT'(screenHeight);

        // Bricks only matter when no wall fired
        checkBricks = moving && !(hitLeft || hitRight || hitTop || hitBottom);
        lifeLost = moving && !(hitLeft || hitRight || hitTop) && hitBottom;
    end

    always_ff @(posedge nextFrame) begin
        if (!rstN) begin
            ballPos <= '{x: resetX, y: heldY};
            velocity <= '0;
            ballHeld <= 1'b1;
        end else if (!gameOver) begin
            if (ballHeld) begin
                // Follow the registered paddle, one frame behind
                ballPos <= '{x: heldX, y: heldY};
                if (control.launch) begin
                    ballHeld <= 1'b0;
                    velocity <= '{x: launchStep, y: launchStep};
                end
            end else if (hitLeft) begin
                ballPos <= '{x: '0, y: candidate.y};
                velocity.x <= -velocity.x;
            end else if (hitRight) begin
                ballPos <= '{x: rightLimit, y: candidate.y};
                velocity.x <= -velocity.x;
            end else if (hitTop) begin
                ballPos <= '{x: candidate.x, y: '0};
                velocity.y <= -velocity.y;
            end else if (hitBottom) begin
                // Ball lost, back onto the paddle
                ballHeld <= 1'b1;
                ballPos <= '{x: heldX, y: heldY};
                velocity <= '0;
            end else begin
                ballPos <= candidate;
                if (brickHit) begin
                    velocity.y <= -velocity.y;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* paddleControl.sv */
`default_nettype none

module paddleControl #(
    parameter int screenWidth = brickGamePkg::screenWidth
) (
    input  logic                  nextFrame,
    input  logic                  rstN,
    input  brickGamePkg::controlT control,
    input  logic                  gameOver,
    output brickGamePkg::coordT   paddleX
);

    // Rightmost position that keeps the paddle on screen
    localparam brickGamePkg::coordT maxX =
        brickGamePkg::coordT'(screenWidth - brickGamePkg::paddleWidth);
    localparam brickGamePkg::coordT speed =
        brickGamePkg::coordT'(brickGamePkg::paddleSpeed);
    localparam brickGamePkg::coordT startX =
        brickGamePkg::coordT'(brickGamePkg::paddleStartX);

    brickGamePkg::coordT movedLeft;
    brickGamePkg::coordT movedRight;
    brickGamePkg::coordT nextX;

    always_comb begin
        movedLeft = paddleX - speed;
        movedRight = paddleX + speed;
        nextX = paddleX;
        // Left wins when both are pressed
        if (control.moveLeft) begin
            nextX = (movedLeft < 0) ? '0 : movedLeft;
        end else if (control.moveRight) begin
            nextX = (movedRight > maxX) ? maxX : movedRight;
        end
    end

    always_ff @(posedge nextFrame) begin
        if (!rstN) begin
            paddleX <= startX;
        end else if (!gameOver) begin
            paddleX <= nextX;
        end
    end

endmodule

`default_nettype wire

/* brickGamePkg.sv */
`default_nettype none

package brickGamePkg;

    // Signed screen coordinate, also used for velocities
    typedef logic signed [11:0] coordT;

    // Position or velocity pair
    typedef struct packed {
        coordT x;
        coordT y;
    } pointT;

    // Decoded controls for one frame
    typedef struct packed {
        logic moveLeft;
        logic moveRight;
        logic launch;
    } controlT;

    // Default playfield
    localparam int screenWidth = 640;
    localparam int screenHeight = 480;

    localparam int ballSize = 8;

    // Paddle geometry and motion
    localparam int paddleWidth = 80;
    localparam int paddleHeight = 8;
    localparam int paddleY = 440;
    localparam int paddleStartX = 280;
    localparam int paddleSpeed = 4;

    // Ball rules
    localparam int holdGap = 5;
    localparam int launchVelocity = 5;

    // Brick grid layout
    localparam int brickRows = 4;
    localparam int brickCols = 8;
    localparam int brickCount = brickRows * brickCols;
    localparam int brickWidth = 48;
    localparam int brickHeight = 16;
    localparam int brickOriginX = 96;
    localparam int brickOriginY = 64;
    localparam int brickPitchX = 56;
    localparam int brickPitchY = 32;

    // Scoring and lives
    localparam int brickScore = 99;
    localparam int startLives = 3;

endpackage

`default_nettype wire
